/* source/pad_pkg.sv */
package pad_pkg;

	// Button bit positions inside a pad_buttons_t
	localparam int PAD_BTN_RIGHT  = 0;
	localparam int PAD_BTN_LEFT   = 1;
	localparam int PAD_BTN_DOWN   = 2;
	localparam int PAD_BTN_UP     = 3;
	localparam int PAD_BTN_A      = 4;
	localparam int PAD_BTN_B      = 5;
	localparam int PAD_BTN_SELECT = 6;
	localparam int PAD_BTN_START  = 7;

	typedef logic [7:0] pad_buttons_t; // 1 = pressed

	localparam int PAD_ADDR_W = 5;

	// Register map
	localparam logic [PAD_ADDR_W-1:0] PAD_REG_CTRL    = 5'h00; // bit0 enable, bit1 irq_en
	localparam logic [PAD_ADDR_W-1:0] PAD_REG_PERIOD  = 5'h04; // Poll period in ticks
	localparam logic [PAD_ADDR_W-1:0] PAD_REG_BUTTONS = 5'h08; // Pad 1 in upper byte
	localparam logic [PAD_ADDR_W-1:0] PAD_REG_PRESS   = 5'h0C; // Sticky, write 1 to clear
	localparam logic [PAD_ADDR_W-1:0] PAD_REG_STATUS  = 5'h10; // busy in bit 16

	localparam logic [1:0] PAD_RESP_OKAY = 2'b00;

endpackage

/* source/pad_tick_gen.sv */
`timescale 1ns/1ps

module pad_tick_gen #(
	parameter int DIV_COUNT = 16
) (
	input  logic clock_in,
	input  logic I_RESET,
	output logic tick
);

	localparam int CNT_W = (DIV_COUNT > 1) ? $clog2(DIV_COUNT) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV_COUNT - 1);

	logic [CNT_W-1:0] count;

	// One-cycle enable instead of a divided clock
	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			count <= '0;
			tick  <= 1'b0;
		end else begin
			tick <= (count == CNT_LAST);
			if (count == CNT_LAST)
				count <= '0;
			else
				count <= count + 1'b1;
		end
	end

endmodule

/* source/pad_serial_reader.sv */
`timescale 1ns/1ps

module pad_serial_reader (
	input  logic                  clock_in,
	input  logic                  I_RESET,
	input  logic                  tick,
	input  logic                  start,
	input  logic                  data,
	output logic                  latch,
	output logic                  pulse,
	output pad_pkg::pad_buttons_t buttons,
	output logic                  done,
	output logic                  busy
);

	import pad_pkg::*;

	localparam logic [4:0] LAST_STEP = 5'd20;

	// Order in which the pad shifts its bits out
	localparam int BIT_ORDER [8] = '{
		PAD_BTN_A, PAD_BTN_B, PAD_BTN_SELECT, PAD_BTN_START,
		PAD_BTN_UP, PAD_BTN_DOWN, PAD_BTN_LEFT, PAD_BTN_RIGHT
	};

	logic [4:0]   step;
	logic [4:0]   step_next;
	logic [2:0]   bit_idx;
	logic         sample;
	logic         step_en;
	pad_buttons_t staging;

	assign step_en   = busy && tick;
	assign step_next = step + 5'd1;
	assign bit_idx   = step_next[3:1] - 3'd2; // (step - 4) / 2

	// Even steps 4..18 take a bit
	assign sample = step_en && !step_next[0] && (step_next >= 5'd4) && (step_next <= 5'd18);

	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			step    <= '0;
			busy    <= 1'b0;
			latch   <= 1'b0;
			pulse   <= 1'b0;
			done    <= 1'b0;
			buttons <= '0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin // Ignored while busy
					busy <= 1'b1;
					step <= '0;
				end
			end else if (tick) begin
				step  <= step_next;
				latch <= (step_next == 5'd1) || (step_next == 5'd2);
				// Odd steps 5..19, one tick wide
				pulse <= step_next[0] && (step_next >= 5'd5) && (step_next <= 5'd19);
				if (step_next == LAST_STEP) begin
					buttons <= staging; // All eight at once
					done    <= 1'b1;
					busy    <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock_in) begin
		if (sample)
			staging[BIT_ORDER[bit_idx]] <= ~data; // Pad data is active low
	end

endmodule

/* source/pad_event_detect.sv */
`timescale 1ns/1ps

module pad_event_detect (
	input  logic                  clock_in,
	input  logic                  I_RESET,
	input  logic                  update,
	input  pad_pkg::pad_buttons_t buttons,
	input  pad_pkg::pad_buttons_t clear,
	output pad_pkg::pad_buttons_t press
);

	import pad_pkg::*;

	pad_buttons_t prev;
	pad_buttons_t kept;
	pad_buttons_t new_press;

	assign kept      = press & ~clear;
	assign new_press = buttons & ~prev;

	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			prev  <= '0;
			press <= '0;
		end else begin
			if (update) begin
				// New press beats a clear in the same cycle
				press <= kept | new_press;
				prev  <= buttons;
			end else begin
				press <= kept;
			end
		end
	end

endmodule

/* source/pad_poll_ctrl.sv */
`timescale 1ns/1ps

module pad_poll_ctrl (
	input  logic        clock_in,
	input  logic        I_RESET,
	input  logic        tick,
	input  logic        enable,
	input  logic        irq_en,
	input  logic [15:0] period,
	input  logic        done0,
	input  logic        done1,
	input  logic        busy0,
	input  logic        busy1,
	input  logic        press_any,
	output logic        start,
	output logic        update,
	output logic [15:0] poll_count,
	output logic        busy,
	output logic        irq
);

	// A read takes 20 ticks, keep polls apart
	localparam logic [15:0] MIN_PERIOD = 16'd21;

	logic [15:0] eff_period;
	logic [15:0] tick_count;
	logic        active;
	logic        got0;
	logic        got1;
	logic        both_done;

	assign eff_period = (period < MIN_PERIOD) ? MIN_PERIOD : period;
	assign both_done  = active && (got0 || done0) && (got1 || done1);
	assign busy       = active;

	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			tick_count <= '0;
			start      <= 1'b0;
			update     <= 1'b0;
			poll_count <= '0;
			active     <= 1'b0;
			got0       <= 1'b0;
			got1       <= 1'b0;
			irq        <= 1'b0;
		end else begin
			start  <= 1'b0;
			update <= both_done;
			irq    <= irq_en && press_any;

			if (!enable) begin
				tick_count <= '0; // Running poll still completes
			end else if (tick) begin
				if (tick_count >= eff_period - 16'd1) begin
					tick_count <= '0;
					if (!active && !busy0 && !busy1) begin
						start  <= 1'b1;
						active <= 1'b1;
					end
				end else begin
					tick_count <= tick_count + 16'd1;
				end
			end

			if (both_done) begin
				active     <= 1'b0;
				got0       <= 1'b0;
				got1       <= 1'b0;
				poll_count <= poll_count + 16'd1;
			end else begin
				if (done0)
					got0 <= 1'b1;
				if (done1)
					got1 <= 1'b1;
			end
		end
	end

endmodule

/* source/pad_axil_regs.sv */
`timescale 1ns/1ps

module pad_axil_regs #(
	parameter int PERIOD_RESET = 40
) (
	input  logic                          clock_in,
	input  logic                          I_RESET,

	input  logic [pad_pkg::PAD_ADDR_W-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [31:0]                   wdata,
	input  logic [3:0]                    wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [pad_pkg::PAD_ADDR_W-1:0] araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [31:0]                   rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,

	input  pad_pkg::pad_buttons_t         buttons0,
	input  pad_pkg::pad_buttons_t         buttons1,
	input  pad_pkg::pad_buttons_t         press0,
	input  pad_pkg::pad_buttons_t         press1,
	input  logic [15:0]                   poll_count,
	input  logic                          busy,

	output logic                          enable,
	output logic                          irq_en,
	output logic [15:0]                   period,
	output logic [15:0]                   press_clear
);

	import pad_pkg::*;

	logic        wr_accept;
	logic        wr_fire;
	logic        rd_accept;
	logic        rd_fire;
	logic [31:0] rd_mux;

	// Held bvalid / rvalid blocks the next transfer
	assign wr_accept = awvalid && wvalid && !awready && !bvalid;
	assign wr_fire   = awvalid && awready;
	assign rd_accept = arvalid && !arready && !rvalid;
	assign rd_fire   = arvalid && arready;

	assign bresp = PAD_RESP_OKAY;
	assign rresp = PAD_RESP_OKAY;

	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			awready     <= 1'b0;
			wready      <= 1'b0;
			bvalid      <= 1'b0;
			enable      <= 1'b0;
			irq_en      <= 1'b0;
			period      <= 16'(PERIOD_RESET);
			press_clear <= '0;
		end else begin
			awready     <= wr_accept;
			wready      <= wr_accept;
			press_clear <= '0;

			if (wr_fire)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			if (wr_fire) begin
				case (awaddr)
					PAD_REG_CTRL: begin
						if (wstrb[0]) begin
							enable <= wdata[0];
							irq_en <= wdata[1];
						end
					end
					PAD_REG_PERIOD: begin
						if (wstrb[0])
							period[7:0] <= wdata[7:0];
						if (wstrb[1])
							period[15:8] <= wdata[15:8];
					end
					PAD_REG_PRESS: begin // One-cycle clear mask
						press_clear[7:0]  <= wstrb[0] ? wdata[7:0] : 8'd0;
						press_clear[15:8] <= wstrb[1] ? wdata[15:8] : 8'd0;
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clock_in) begin
		if (I_RESET) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else begin
			arready <= rd_accept;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_comb begin
		case (araddr)
			PAD_REG_CTRL:    rd_mux = {30'd0, irq_en, enable};
			PAD_REG_PERIOD:  rd_mux = {16'd0, period};
			PAD_REG_BUTTONS: rd_mux = {16'd0, buttons1, buttons0};
			PAD_REG_PRESS:   rd_mux = {16'd0, press1, press0};
			PAD_REG_STATUS:  rd_mux = {15'd0, busy, poll_count};
			default:         rd_mux = 32'd0; // Unmapped reads zero
		endcase
	end

	always_ff @(posedge clock_in) begin
		if (rd_fire)
			rdata <= rd_mux;
	end

endmodule

/* source/pad_subsystem.sv */
`timescale 1ns/1ps

module pad_subsystem #(
	parameter int DIV_COUNT    = 1024,
	parameter int PERIOD_RESET = 40
) (
	input  logic                          clock_in,
	input  logic                          I_RESET,

	input  logic [pad_pkg::PAD_ADDR_W-1:0] awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [31:0]                   wdata,
	input  logic [3:0]                    wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	output logic [1:0]                    bresp,
	output logic                          bvalid,
	input  logic                          bready,
	input  logic [pad_pkg::PAD_ADDR_W-1:0] araddr,
	input  logic                          arvalid,
	output logic                          arready,
	output logic [31:0]                   rdata,
	output logic [1:0]                    rresp,
	output logic                          rvalid,
	input  logic                          rready,

	output logic                          pad0_latch,
	output logic                          pad0_pulse,
	input  logic                          pad0_data,
	output logic                          pad1_latch,
	output logic                          pad1_pulse,
	input  logic                          pad1_data,

	output logic                          irq
);

	import pad_pkg::*;

	logic         tick;
	logic         start;
	logic         update;
	logic         done0;
	logic         done1;
	logic         busy0;
	logic         busy1;
	logic         busy;
	logic         enable;
	logic         irq_en;
	logic         press_any;
	logic [15:0]  period;
	logic [15:0]  press_clear;
	logic [15:0]  poll_count;
	pad_buttons_t buttons0;
	pad_buttons_t buttons1;
	pad_buttons_t press0;
	pad_buttons_t press1;

	assign press_any = (|press0) || (|press1);

	pad_tick_gen #(.DIV_COUNT(DIV_COUNT)) u_tick (
		.clock_in(clock_in), .I_RESET(I_RESET), .tick(tick)
	);

	pad_serial_reader u_reader0 (
		.clock_in(clock_in), .I_RESET(I_RESET), .tick(tick), .start(start),
		.data(pad0_data), .latch(pad0_latch), .pulse(pad0_pulse),
		.buttons(buttons0), .done(done0), .busy(busy0)
	);

	pad_serial_reader u_reader1 (
		.clock_in(clock_in), .I_RESET(I_RESET), .tick(tick), .start(start),
		.data(pad1_data), .latch(pad1_latch), .pulse(pad1_pulse),
		.buttons(buttons1), .done(done1), .busy(busy1)
	);

	pad_event_detect u_detect0 (
		.clock_in(clock_in), .I_RESET(I_RESET), .update(update),
		.buttons(buttons0), .clear(press_clear[7:0]), .press(press0)
	);

	pad_event_detect u_detect1 (
		.clock_in(clock_in), .I_RESET(I_RESET), .update(update),
		.buttons(buttons1), .clear(press_clear[15:8]), .press(press1)
	);

	pad_poll_ctrl u_ctrl (
		.clock_in(clock_in), .I_RESET(I_RESET), .tick(tick),
		.enable(enable), .irq_en(irq_en), .period(period),
		.done0(done0), .done1(done1), .busy0(busy0), .busy1(busy1),
		.press_any(press_any), .start(start), .update(update),
		.poll_count(poll_count), .busy(busy), .irq(irq)
	);

	pad_axil_regs #(.PERIOD_RESET(PERIOD_RESET)) u_regs (
		.clock_in(clock_in), .I_RESET(I_RESET),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.buttons0(buttons0), .buttons1(buttons1),
		.press0(press0), .press1(press1),
		.poll_count(poll_count), .busy(busy),
		.enable(enable), .irq_en(irq_en), .period(period),
		.press_clear(press_clear)
	);

endmodule

/* test/pad_model.sv */
`timescale 1ns/1ps

module pad_model (
	input  logic                  clock_in,
	input  logic                  latch,
	input  logic                  pulse,
	input  pad_pkg::pad_buttons_t buttons,
	output logic                  data
);

	import pad_pkg::*;

	logic [7:0] shift_reg = 8'hFF; // Released pad shifts out ones
	logic       pulse_d   = 1'b0;

	// A is on the line first
	assign data = shift_reg[7];

	always @(posedge clock_in) begin
		pulse_d <= pulse;
		if (latch) begin
			// Parallel load, active low on the wire
			shift_reg <= ~{
				buttons[PAD_BTN_A],
				buttons[PAD_BTN_B],
				buttons[PAD_BTN_SELECT],
				buttons[PAD_BTN_START],
				buttons[PAD_BTN_UP],
				buttons[PAD_BTN_DOWN],
				buttons[PAD_BTN_LEFT],
				buttons[PAD_BTN_RIGHT]
			};
		end else if (pulse && !pulse_d) begin
			shift_reg <= {shift_reg[6:0], 1'b1}; // Next bit on rising pulse
		end
	end

endmodule

/* test/tb_pad_subsystem.sv */
`timescale 1ns/1ps

module tb_pad_subsystem;

	import pad_pkg::*;

	localparam int DIV       = 16;
	localparam int PERIOD_TB = 25;
	localparam int HS_LIMIT  = 50;   // Cycles per handshake
	localparam int POLL_LIMIT = 400; // Status reads per wait
	localparam int ROWS      = 8;

	logic                  clock_in = 1'b0;
	logic                  I_RESET;
	logic [PAD_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [31:0]           wdata;
	logic [3:0]            wstrb;
	logic                  wvalid;
	logic                  wready;
	logic [1:0]            bresp;
	logic                  bvalid;
	logic                  bready;
	logic [PAD_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic [31:0]           rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;
	logic                  pad0_latch;
	logic                  pad0_pulse;
	logic                  pad0_data;
	logic                  pad1_latch;
	logic                  pad1_pulse;
	logic                  pad1_data;
	logic                  irq;
	pad_buttons_t          pad0_set;
	pad_buttons_t          pad1_set;

	// Stimulus rows: pad 0, pad 1, PRESS clear mask applied after the checks (0 = none)
	pad_buttons_t pad0_tab [ROWS] = '{8'h10, 8'h30, 8'h01, 8'hFF, 8'h00, 8'h00, 8'h00, 8'h00};
	pad_buttons_t pad1_tab [ROWS] = '{8'h80, 8'h80, 8'h04, 8'h7E, 8'hFF, 8'h00, 8'h00, 8'h00};
	logic [15:0]  clear_tab [ROWS] = '{16'h0000, 16'h0010, 16'h0000, 16'hFFFF, 16'h8001,
		16'h0000, 16'h0000, 16'h0000};

	pad_buttons_t prev0 = '0;
	pad_buttons_t prev1 = '0;
	pad_buttons_t sticky0 = '0;
	pad_buttons_t sticky1 = '0;
	logic [31:0]  rd_val;
	logic [15:0]  count_before;
	logic [15:0]  count_after;
	int           tries;

	always #20 clock_in = ~clock_in;

	pad_subsystem #(.DIV_COUNT(DIV), .PERIOD_RESET(40)) u_dut (.*);

	pad_model u_pad0 (
		.clock_in(clock_in), .latch(pad0_latch), .pulse(pad0_pulse),
		.buttons(pad0_set), .data(pad0_data)
	);

	pad_model u_pad1 (
		.clock_in(clock_in), .latch(pad1_latch), .pulse(pad1_pulse),
		.buttons(pad1_set), .data(pad1_data)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else
			fail_run($sformatf("mismatch at %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, got, exp));
	endtask

	task automatic axi_write(input logic [PAD_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int waited;
		@(posedge clock_in);
		#1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		waited  = 0;
		while (!(awready && wready)) begin
			if (waited == HS_LIMIT)
				fail_run("write address and data were never accepted");
			@(posedge clock_in);
			#1;
			waited++;
		end
		@(posedge clock_in); // Transfer edge
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		waited  = 0;
		while (!bvalid) begin
			if (waited == HS_LIMIT)
				fail_run("no write response arrived");
			@(posedge clock_in);
			#1;
			waited++;
		end
		check_value("bresp", {30'd0, bresp}, 32'd0); // OKAY
	endtask

	task automatic read_reg(input logic [PAD_ADDR_W-1:0] addr, output logic [31:0] data);
		int waited;
		@(posedge clock_in);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		waited  = 0;
		while (!arready) begin
			if (waited == HS_LIMIT)
				fail_run("read address was never accepted");
			@(posedge clock_in);
			#1;
			waited++;
		end
		@(posedge clock_in);
		#1;
		arvalid = 1'b0;
		waited  = 0;
		while (!rvalid) begin
			if (waited == HS_LIMIT)
				fail_run("no read data arrived");
			@(posedge clock_in);
			#1;
			waited++;
		end
		data = rdata;
		check_value("rresp", {30'd0, rresp}, 32'd0); // OKAY
	endtask

	task automatic read_check(input logic [PAD_ADDR_W-1:0] addr, input logic [31:0] exp,
		input string name);
		logic [31:0] got;
		read_reg(addr, got);
		check_value(name, got, exp);
	endtask

	// Poll STATUS until the count has moved on by count polls
	task automatic wait_polls(input int count);
		logic [31:0] status;
		int base;
		int waited;
		read_reg(PAD_REG_STATUS, status);
		base   = int'(status[15:0]);
		waited = 0;
		while (int'(status[15:0]) < base + count) begin
			if (waited == POLL_LIMIT)
				fail_run("poll count did not advance in time");
			repeat (8) @(posedge clock_in);
			read_reg(PAD_REG_STATUS, status);
			waited++;
		end
	endtask

	initial begin
		#5_000_000;
		fail_run("simulation ran past its time limit");
	end

	initial begin
		void'($urandom(79));
		I_RESET  = 1'b1;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b1;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b1;
		pad0_set = '0;
		pad1_set = '0;
		for (int i = 5; i < ROWS; i++) begin
			pad0_tab[i]  = pad_buttons_t'($urandom() & 32'hFF);
			pad1_tab[i]  = pad_buttons_t'($urandom() & 32'hFF);
			clear_tab[i] = 16'($urandom() & 32'hFFFF);
		end
		repeat (10) @(posedge clock_in);
		#1;
		I_RESET = 1'b0;

		// Reset values
		read_check(PAD_REG_CTRL, 32'd0, "CTRL");
		read_check(PAD_REG_PERIOD, 32'd40, "PERIOD");
		read_check(PAD_REG_BUTTONS, 32'd0, "BUTTONS");
		read_check(PAD_REG_PRESS, 32'd0, "PRESS");
		read_check(PAD_REG_STATUS, 32'd0, "STATUS");
		check_value("irq", {31'd0, irq}, 32'd0);
		check_value("pad0_latch", {31'd0, pad0_latch}, 32'd0);
		check_value("pad1_pulse", {31'd0, pad1_pulse}, 32'd0);
		repeat (2000) @(posedge clock_in);
		#1;
		read_check(PAD_REG_STATUS, 32'd0, "STATUS while disabled");
		check_value("pad1_latch", {31'd0, pad1_latch}, 32'd0);
		check_value("pad0_pulse", {31'd0, pad0_pulse}, 32'd0);

		// Register access and byte strobes
		axi_write(PAD_REG_CTRL, 32'h2, 4'b0001);
		read_check(PAD_REG_CTRL, 32'h2, "CTRL");
		axi_write(PAD_REG_PERIOD, 32'h0000_1234, 4'b0011);
		read_check(PAD_REG_PERIOD, 32'h1234, "PERIOD");
		axi_write(PAD_REG_PERIOD, 32'h0000_5619, 4'b0001);
		read_check(PAD_REG_PERIOD, 32'h1219, "PERIOD low byte");
		axi_write(PAD_REG_PERIOD, 32'h0000_0000, 4'b0010);
		read_check(PAD_REG_PERIOD, PERIOD_TB, "PERIOD high byte");
		read_check(5'h14, 32'd0, "unmapped 0x14");
		read_check(5'h1C, 32'd0, "unmapped 0x1C");
		axi_write(PAD_REG_CTRL, 32'h3, 4'b0001);

		for (int i = 0; i < ROWS; i++) begin
			@(posedge clock_in);
			#1;
			pad0_set = pad0_tab[i];
			pad1_set = pad1_tab[i];
			wait_polls(2);
			sticky0 = sticky0 | (pad0_tab[i] & ~prev0); // Newly pressed since last set
			sticky1 = sticky1 | (pad1_tab[i] & ~prev1);
			prev0   = pad0_tab[i];
			prev1   = pad1_tab[i];
			read_check(PAD_REG_BUTTONS, {16'd0, pad1_tab[i], pad0_tab[i]}, "BUTTONS");
			read_check(PAD_REG_PRESS, {16'd0, sticky1, sticky0}, "PRESS");
			check_value("irq", {31'd0, irq}, {31'd0, (sticky0 | sticky1) != 8'd0});
			if ((sticky0 | sticky1) != 8'd0) begin
				// irq gated by irq_en
				axi_write(PAD_REG_CTRL, 32'h1, 4'b0001);
				read_check(PAD_REG_CTRL, 32'h1, "CTRL");
				check_value("irq with irq_en clear", {31'd0, irq}, 32'd0);
				axi_write(PAD_REG_CTRL, 32'h3, 4'b0001);
				read_check(PAD_REG_CTRL, 32'h3, "CTRL");
				check_value("irq with irq_en set", {31'd0, irq}, 32'd1);
			end
			if (clear_tab[i] != 16'd0) begin
				axi_write(PAD_REG_PRESS, {16'd0, clear_tab[i]}, 4'b0011);
				sticky0 = sticky0 & ~clear_tab[i][7:0];
				sticky1 = sticky1 & ~clear_tab[i][15:8];
				read_check(PAD_REG_PRESS, {16'd0, sticky1, sticky0}, "PRESS after clear");
				check_value("irq after clear", {31'd0, irq},
					{31'd0, (sticky0 | sticky1) != 8'd0});
			end
		end

		// Disable, let a running poll drain, then the count must hold
		axi_write(PAD_REG_CTRL, 32'h2, 4'b0001);
		read_reg(PAD_REG_STATUS, rd_val);
		count_before = rd_val[15:0];
		tries        = 0;
		while (rd_val[16]) begin
			if (tries == POLL_LIMIT)
				fail_run("poll still busy long after polling was disabled");
			repeat (8) @(posedge clock_in);
			read_reg(PAD_REG_STATUS, rd_val);
			tries++;
		end
		count_after = rd_val[15:0];
		assert (count_after - count_before <= 16'd1) else
			fail_run($sformatf("mismatch at %0t: poll count is 0x%0h, expected at most 0x%0h",
				$time, count_after, count_before + 16'd1));
		repeat (3 * PERIOD_TB * DIV) @(posedge clock_in);
		#1;
		read_reg(PAD_REG_STATUS, rd_val);
		check_value("poll count after disable", {16'd0, rd_val[15:0]}, {16'd0, count_after});

		$display("Testbench passed");
		$finish;
	end

endmodule

/* filelist.f */
source/pad_pkg.sv
source/pad_tick_gen.sv
source/pad_serial_reader.sv
source/pad_event_detect.sv
source/pad_poll_ctrl.sv
source/pad_axil_regs.sv
source/pad_subsystem.sv
test/pad_model.sv
test/tb_pad_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_pad_subsystem -f filelist.f \
	> sim.log 2>&1 && ./obj_dir/Vtb_pad_subsystem >> sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "Testbench passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
